// File: common/sprite_cfg.svh
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// table size
//////////////////////////////////////////////////////////////////////

`define SPRITE_COUNT 31  // entries 1..31, number 0 is never stored
`define HALF_SIZE    16  // slots per half, high half builds only 15
`define IDX_W        5   // sprite number width

//////////////////////////////////////////////////////////////////////
// field widths
//////////////////////////////////////////////////////////////////////

`define COORD_W      9   // x and y
`define OFFSET_W     9   // pattern offset
`define DATA_W       32  // host data word

//////////////////////////////////////////////////////////////////////
// slice positions in the host data word
//////////////////////////////////////////////////////////////////////

`define OFFSET_LSB   0
`define Y_LSB        9
`define X_LSB        19  // bit 18 is unused

// answer when no valid entry sits at the probed position
`define MISS_OFFSET  1

`endif

// File: common/sprite_pkg.sv
`include "sprite_cfg.svh"

package sprite_pkg;

	//////////////////////////////////////////////////////////////////////
	// scalar types of the stored sprite data
	//////////////////////////////////////////////////////////////////////

	typedef logic [`COORD_W-1:0]  coord_t;       // one screen coordinate
	typedef logic [`OFFSET_W-1:0] offset_t;      // pattern offset
	typedef logic [`IDX_W-1:0]    sprite_idx_t;  // entry number

	//////////////////////////////////////////////////////////////////////
	// composite types
	//////////////////////////////////////////////////////////////////////

	// lookup key, x in the upper half
	typedef struct packed {
		coord_t x;
		coord_t y;
	} position_t;

	// one stored entry without its valid bit
	typedef struct packed {
		position_t pos;
		offset_t   offset;
	} sprite_entry_t;

	// answer of one half of the table
	typedef struct packed {
		logic    hit;     // some valid entry matched
		offset_t offset;  // offset of the first match
	} lookup_res_t;

endpackage

// File: common/host_pkg.sv
`include "sprite_cfg.svh"

package host_pkg;

	import sprite_pkg::*;

	typedef logic [`DATA_W-1:0] host_data_t;  // raw host data word

	// which field of an entry a write targets
	typedef enum logic [1:0] {
		field_offset = 2'd0,
		field_y      = 2'd1,
		field_x      = 2'd2,
		field_none   = 2'd3   // write is ignored
	} field_sel_t;

	//////////////////////////////////////////////////////////////////////
	// host write command, 40 bits
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        wr;     // one-cycle strobe
		sprite_idx_t idx;    // target sprite 1..31
		field_sel_t  field;  // field to update
		host_data_t  data;   // sliced per field
	} host_wr_t;

endpackage

// File: sprite_bank/sprite_half.sv
`include "sprite_cfg.svh"

module sprite_half
	import sprite_pkg::*;
	import host_pkg::*;
#(
	parameter int BASE = 1  // first sprite number held here
) (
	input  logic        clk,
	input  logic        rst,
	input  host_wr_t    wr_cmd,
	input  position_t   check,
	output lookup_res_t result,
	output logic        wr_ok
);

	// slots past the last sprite number are not built
	localparam int REMAIN = `SPRITE_COUNT - BASE + 1;
	localparam int SLOTS  = (REMAIN < `HALF_SIZE) ? REMAIN : `HALF_SIZE;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	sprite_entry_t    entries [SLOTS];  // position and offset per slot
	logic [SLOTS-1:0] valid;            // slot written since reset
	logic [SLOTS-1:0] wr_hit;           // one-hot slot select of a write

	//////////////////////////////////////////////////////////////////////
	// write decode
	//////////////////////////////////////////////////////////////////////

	// sprite 0 and numbers of the other half never decode here
	always_comb begin
		for (int i = 0; i < SLOTS; i++) begin
			wr_hit[i] = wr_cmd.wr
				&& (wr_cmd.field != field_none)
				&& (wr_cmd.idx == sprite_idx_t'(BASE + i));
		end
	end

	// only the selected field changes, the others keep their value
	always_ff @(posedge clk) begin
		for (int i = 0; i < SLOTS; i++) begin
			if (wr_hit[i]) begin
				case (wr_cmd.field)
					field_offset: entries[i].offset <= wr_cmd.data[`OFFSET_LSB +: `OFFSET_W];
					field_y:      entries[i].pos.y  <= wr_cmd.data[`Y_LSB +: `COORD_W];
					field_x:      entries[i].pos.x  <= wr_cmd.data[`X_LSB +: `COORD_W];
					default:      ;  // filtered out by the decode
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;  // nothing matches after reset
			wr_ok <= 1'b0;
		end else begin
			valid <= valid | wr_hit;  // any field write validates
			wr_ok <= |wr_hit;         // one-cycle success pulse
		end
	end

	//////////////////////////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////////////////////////

	// scanned from the top so the lowest matching slot is the last to land
	always_comb begin
		result.hit    = 1'b0;
		result.offset = '0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (valid[i] && (entries[i].pos == check)) begin
				result.hit    = 1'b1;
				result.offset = entries[i].offset;
			end
		end
		if (wr_cmd.wr) begin
			result.hit = 1'b0;  // no lookup during a write
		end
	end

endmodule

// File: src/lookup_merge.sv
`include "sprite_cfg.svh"

module lookup_merge
	import sprite_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  lookup_res_t low_res,   // sprites 1..16
	input  lookup_res_t high_res,  // sprites 17..31
	input  logic        low_ok,
	input  logic        high_ok,
	output offset_t     read_data,
	output logic        success
);

	localparam offset_t MISS = offset_t'(`MISS_OFFSET);

	//////////////////////////////////////////////////////////////////////
	// priority select
	//////////////////////////////////////////////////////////////////////

	offset_t next_data;

	// every low-half number is below every high-half number
	always_comb begin
		if (low_res.hit) begin
			next_data = low_res.offset;
		end else if (high_res.hit) begin
			next_data = high_res.offset;
		end else begin
			next_data = MISS;  // no match or write in progress
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			read_data <= MISS;
		end else begin
			read_data <= next_data;  // valid one cycle after check
		end
	end

	// both pulses are already registered in the halves
	// and at most one is high for a given write
	assign success = low_ok | high_ok;

endmodule

// File: src/sprite_table_top.sv
module sprite_table_top
	import sprite_pkg::*;
	import host_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        wr,            // write strobe, blocks the lookup
	input  sprite_idx_t n_reg,         // sprite number 1..31
	input  field_sel_t  select_field,
	input  host_data_t  data,
	input  position_t   check,         // lookup coordinate
	output offset_t     read_data,
	output logic        success
);

	//////////////////////////////////////////////////////////////////////
	// write command fanned out to both halves
	//////////////////////////////////////////////////////////////////////

	host_wr_t    wr_cmd;
	lookup_res_t low_res;
	lookup_res_t high_res;
	logic        low_ok;
	logic        high_ok;

	assign wr_cmd = '{wr: wr, idx: n_reg, field: select_field, data: data};

	//////////////////////////////////////////////////////////////////////
	// table halves
	//////////////////////////////////////////////////////////////////////

	sprite_half #(.BASE(1)) i_low (  // sprites 1..16
		.clk    (clk),
		.rst    (rst),
		.wr_cmd (wr_cmd),
		.check  (check),
		.result (low_res),
		.wr_ok  (low_ok)
	);

	sprite_half #(.BASE(17)) i_high (  // sprites 17..31
		.clk    (clk),
		.rst    (rst),
		.wr_cmd (wr_cmd),
		.check  (check),
		.result (high_res),
		.wr_ok  (high_ok)
	);

	lookup_merge i_merge (
		.clk       (clk),
		.rst       (rst),
		.low_res   (low_res),
		.high_res  (high_res),
		.low_ok    (low_ok),
		.high_ok   (high_ok),
		.read_data (read_data),
		.success   (success)
	);

endmodule

// File: verif/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#2 rst = 1'b0;  // released off the edge like the other inputs
	end

endmodule

// File: verif/tb_checker.sv
module tb_checker
	import sprite_pkg::*;
#(
	parameter int ROWS = 1
) (
	input  logic    clk,
	input  logic    success,
	input  offset_t read_data,
	input  logic    row_active,        // a table row is on the DUT inputs
	input  int      row_idx,
	input  logic    exp_ok   [ROWS],
	input  offset_t exp_data [ROWS],
	output int      pass_cnt,
	output int      fail_cnt
);

	timeunit 1ns;
	timeprecision 100ps;

	logic prev_active;  // row sampled at the last edge
	int   prev_idx;

	initial begin
		prev_active = 1'b0;
		prev_idx    = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
	end

	always @(posedge clk) begin
		prev_active <= row_active;
		prev_idx    <= row_idx;
	end

	// registered outputs have settled by the falling edge
	always @(negedge clk) begin
		if (prev_active) begin
			if (success !== exp_ok[prev_idx] || read_data !== exp_data[prev_idx]) begin
				$display("FAIL %0t row %0d: success %b read_data %h, expected %b %h",
					$time, prev_idx, success, read_data,
					exp_ok[prev_idx], exp_data[prev_idx]);
				fail_cnt++;
			end else begin
				$display("row %0d ok: success %b read_data %h",
					prev_idx, success, read_data);
				pass_cnt++;
			end
		end
	end

endmodule

// File: verif/tb_top.sv
module tb_top
	import sprite_pkg::*;
	import host_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int      ROWS  = 28;
	localparam int      CYCLE = 40;
	localparam offset_t MISS  = 9'd1;  // answer with no match

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        wr;
		sprite_idx_t n_reg;
		field_sel_t  sel;
		host_data_t  data;
		position_t   check;
	} row_t;

	row_t    rows     [ROWS];
	logic    exp_ok   [ROWS];
	offset_t exp_data [ROWS];
	int      n_rows;

	logic        clk;
	logic        rst;
	logic        wr;
	sprite_idx_t n_reg;
	field_sel_t  select_field;
	host_data_t  data;
	position_t   check;
	offset_t     read_data;
	logic        success;
	logic        row_active;
	int          row_idx;
	int          pass_cnt;
	int          fail_cnt;

	// all other bits set, so a write must ignore them
	function automatic host_data_t place_field(field_sel_t sel, coord_t value);
		host_data_t word;
		word = '1;
		case (sel)
			field_y: word[17:9]  = value;
			field_x: word[27:19] = value;
			default: word[8:0]   = value;
		endcase
		return word;
	endfunction

	function automatic logic accepted(sprite_idx_t idx, field_sel_t sel);
		return (idx != '0) && (sel != field_none);
	endfunction

	task automatic add_row(input logic w, input sprite_idx_t idx, input field_sel_t sel,
			input coord_t value, input coord_t cx, input coord_t cy, input offset_t exp);
		rows[n_rows].wr      = w;
		rows[n_rows].n_reg   = idx;
		rows[n_rows].sel     = sel;
		rows[n_rows].data    = place_field(sel, value);
		rows[n_rows].check.x = cx;
		rows[n_rows].check.y = cy;
		exp_ok[n_rows]       = w && accepted(idx, sel);
		exp_data[n_rows]     = exp;
		n_rows++;
	endtask

	task automatic add_write(input sprite_idx_t idx, input field_sel_t sel, input coord_t value);
		add_row(1'b1, idx, sel, value, '0, '0, MISS);  // no lookup while writing
	endtask

	task automatic add_lookup(input coord_t cx, input coord_t cy, input offset_t exp);
		add_row(1'b0, '0, field_none, '0, cx, cy, exp);
	endtask

	task automatic build_table();
		n_rows = 0;
		add_lookup(0, 0, MISS);  // reset state
		add_write(5, field_offset, 9'h0a5);
		add_write(5, field_y, 40);
		add_write(5, field_x, 100);
		add_lookup(100, 40, 9'h0a5);
		add_write(0, field_x, 12);      // sprite 0 is never stored
		add_write(5, field_none, 12);
		add_lookup(100, 40, 9'h0a5);
		add_write(20, field_offset, 9'h133);
		add_write(20, field_y, 77);
		add_write(20, field_x, 300);
		add_lookup(300, 77, 9'h133);    // high half alone
		add_write(3, field_offset, 9'h055);
		add_write(3, field_y, 77);
		add_write(3, field_x, 300);
		add_lookup(300, 77, 9'h055);    // lower number wins
		add_write(3, field_x, 301);
		add_lookup(300, 77, 9'h133);
		add_lookup(301, 77, 9'h055);
		add_lookup(12, 34, MISS);
		add_row(1'b1, 5, field_offset, 9'h0a5, 100, 40, MISS);  // write hides a hit
		add_lookup(100, 40, 9'h0a5);
		add_write(7, field_offset, 9'h1fe);
		add_write(7, field_y, 511);
		add_write(7, field_x, 511);
		add_lookup(511, 511, 9'h1fe);   // right after the write
		add_write(7, field_y, 0);
		add_lookup(511, 0, 9'h1fe);
	endtask

	//////////////////////////////////////////////////////////////////////
	// instances
	//////////////////////////////////////////////////////////////////////

	tb_clock i_clock (
		.clk (clk),
		.rst (rst)
	);

	sprite_table_top i_dut (
		.clk          (clk),
		.rst          (rst),
		.wr           (wr),
		.n_reg        (n_reg),
		.select_field (select_field),
		.data         (data),
		.check        (check),
		.read_data    (read_data),
		.success      (success)
	);

	tb_checker #(.ROWS(ROWS)) i_checker (
		.clk        (clk),
		.success    (success),
		.read_data  (read_data),
		.row_active (row_active),
		.row_idx    (row_idx),
		.exp_ok     (exp_ok),
		.exp_data   (exp_data),
		.pass_cnt   (pass_cnt),
		.fail_cnt   (fail_cnt)
	);

	//////////////////////////////////////////////////////////////////////
	// drive loop and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		wr           = 1'b0;
		n_reg        = '0;
		select_field = field_none;
		data         = '0;
		check        = '0;
		row_active   = 1'b0;
		row_idx      = 0;
		build_table();
		@(negedge rst);  // end of the reset pulse
		for (int r = 0; r < ROWS; r++) begin
			@(posedge clk);
			#2;
			wr           = rows[r].wr;
			n_reg        = rows[r].n_reg;
			select_field = rows[r].sel;
			data         = rows[r].data;
			check        = rows[r].check;
			row_idx      = r;
			row_active   = 1'b1;
		end
		@(posedge clk);
		#2;
		wr         = 1'b0;
		row_active = 1'b0;
		wait (pass_cnt + fail_cnt == ROWS);
		$display("rows checked: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#((ROWS + 10) * CYCLE);
		$display("timeout: not all rows were checked within %0d ns", (ROWS + 10) * CYCLE);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: sprite_table.f
+incdir+common
common/sprite_pkg.sv
common/host_pkg.sv
sprite_bank/sprite_half.sv
src/lookup_merge.sv
src/sprite_table_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --top-module tb_top -f sprite_table.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" && exit 0 || exit 1
